// ==== warp_looper_defs.svh ====
`ifndef WARP_LOOPER_DEFS_SVH
`define WARP_LOOPER_DEFS_SVH
`default_nettype none

// ========================================
// Looper dimensions
// ========================================

// Address lanes produced per vector
`define WL_VSIZE 4

// Memory address width
`define WL_ABW 16

// One A or B offset coordinate
`define WL_WBW 8

// Configurations selectable by id
`define WL_NCFG 4

// Id width with one extra bit on range bounds so the end can reach WL_NCFG
`define WL_IDW 2

`default_nettype wire
`endif

// ==== warp_looper_pkg.sv ====
`default_nettype none

// ========================================
// Shared looper types
// ========================================

package warp_looper_pkg;

	// Index loop control state
	typedef enum logic {
		LOOP_IDLE = 1'b0,
		LOOP_RUN  = 1'b1
	} loop_state_e;

	// Opcode travelling with every step
	// STEP_LAST marks the final step of a command
	typedef enum logic {
		STEP_MID  = 1'b0,
		STEP_LAST = 1'b1
	} step_op_e;

endpackage

`default_nettype wire

// ==== warp_index_loop.sv ====
`timescale 1ns/1ps
`include "warp_looper_defs.svh"
`default_nettype none

module warp_index_loop import warp_looper_pkg::*; (
	input  logic               i_clk,
	input  logic               i_rst_n,
	// Command side
	input  logic               i_cmd_rdy,
	output logic               o_cmd_ack,
	input  logic [`WL_WBW-1:0] i_abeg_x,
	input  logic [`WL_WBW-1:0] i_abeg_y,
	input  logic [`WL_WBW-1:0] i_aend_x,
	input  logic [`WL_WBW-1:0] i_aend_y,
	input  logic [`WL_IDW:0]   i_id_beg,
	input  logic [`WL_IDW:0]   i_id_end,
	// Step side
	output logic               o_step_rdy,
	input  logic               i_step_ack,
	output logic [`WL_IDW-1:0] o_id,
	output logic [`WL_WBW-1:0] o_ax,
	output logic [`WL_WBW-1:0] o_ay,
	output step_op_e           o_op
);

	// ========================================
	// Declarations
	// ========================================

	loop_state_e state_r;

	// Bounds captured at command accept
	logic [`WL_WBW-1:0] abeg_x_r;
	logic [`WL_WBW-1:0] aend_x_r;
	logic [`WL_WBW-1:0] aend_y_r;
	logic [`WL_IDW:0]   id_beg_r;
	logic [`WL_IDW:0]   id_end_r;

	// Loop counters with id running fastest
	logic [`WL_IDW:0]   cnt_id;
	logic [`WL_WBW-1:0] cnt_ax;
	logic [`WL_WBW-1:0] cnt_ay;

	logic cmd_fire;
	logic cmd_empty;
	logic step_fire;
	logic last_id;
	logic last_x;
	logic last_y;
	logic last_step;

	// ========================================
	// Handshake and wrap detection
	// ========================================

	assign o_cmd_ack  = (state_r == LOOP_IDLE) && i_cmd_rdy;
	assign cmd_fire   = o_cmd_ack;
	assign o_step_rdy = (state_r == LOOP_RUN);
	assign step_fire  = o_step_rdy && i_step_ack;

	// Any empty dimension means nothing to emit
	assign cmd_empty = (i_id_end <= i_id_beg)
		|| (i_aend_x <= i_abeg_x)
		|| (i_aend_y <= i_abeg_y);

	assign last_id   = (cnt_id + 1'b1) == id_end_r;
	assign last_x    = (cnt_ax + 1'b1) == aend_x_r;
	assign last_y    = (cnt_ay + 1'b1) == aend_y_r;
	assign last_step = last_id && last_x && last_y;

	assign o_id = cnt_id[`WL_IDW-1:0];
	assign o_ax = cnt_ax;
	assign o_ay = cnt_ay;
	assign o_op = last_step ? STEP_LAST : STEP_MID;

	// ========================================
	// Control FSM
	// ========================================

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r <= LOOP_IDLE;
		end else begin
			unique case (state_r)
				LOOP_IDLE: begin
					if (cmd_fire && !cmd_empty) begin
						state_r <= LOOP_RUN;
					end
				end
				LOOP_RUN: begin
					if (step_fire && last_step) begin
						state_r <= LOOP_IDLE;
					end
				end
				default: state_r <= LOOP_IDLE;
			endcase
		end
	end

	// Counters start at the range begin and step on every accepted step
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt_id <= '0;
			cnt_ax <= '0;
			cnt_ay <= '0;
		end else if (cmd_fire) begin
			cnt_id <= i_id_beg;
			cnt_ax <= i_abeg_x;
			cnt_ay <= i_abeg_y;
		end else if (step_fire && !last_step) begin
			if (!last_id) begin
				cnt_id <= cnt_id + 1'b1;
			end else begin
				cnt_id <= id_beg_r;
				if (!last_x) begin
					cnt_ax <= cnt_ax + 1'b1;
				end else begin
					cnt_ax <= abeg_x_r;
					cnt_ay <= cnt_ay + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (cmd_fire) begin
			abeg_x_r <= i_abeg_x;
			aend_x_r <= i_aend_x;
			aend_y_r <= i_aend_y;
			id_beg_r <= i_id_beg;
			id_end_r <= i_id_end;
		end
	end

	// Offered id never reaches the end bound of the running command
	a_id_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_step_rdy |-> (cnt_id < id_end_r))
		else $error("index loop offered id %0d outside range end %0d", cnt_id, id_end_r);

endmodule

`default_nettype wire

// ==== warp_step_fifo.sv ====
`timescale 1ns/1ps
`include "warp_looper_defs.svh"
`default_nettype none

module warp_step_fifo import warp_looper_pkg::*; (
	input  logic               i_clk,
	input  logic               i_rst_n,
	// Write side
	input  logic               i_rdy,
	output logic               o_ack,
	input  logic [`WL_IDW-1:0] i_id,
	input  logic [`WL_WBW-1:0] i_ax,
	input  logic [`WL_WBW-1:0] i_ay,
	input  step_op_e           i_op,
	// Read side
	output logic               o_rdy,
	input  logic               i_ack,
	output logic [`WL_IDW-1:0] o_id,
	output logic [`WL_WBW-1:0] o_ax,
	output logic [`WL_WBW-1:0] o_ay,
	output step_op_e           o_op
);

	// Two entries of step storage
	logic [`WL_IDW-1:0] mem_id [2];
	logic [`WL_WBW-1:0] mem_ax [2];
	logic [`WL_WBW-1:0] mem_ay [2];
	step_op_e           mem_op [2];

	logic       wptr;
	logic       rptr;
	logic [1:0] count;
	logic       push;
	logic       pop;

	// Accept only while there is a free slot
	assign o_ack = i_rdy && (count != 2'd2);
	assign o_rdy = (count != 2'd0);
	assign push  = o_ack;
	assign pop   = o_rdy && i_ack;

	assign o_id = mem_id[rptr];
	assign o_ax = mem_ax[rptr];
	assign o_ay = mem_ay[rptr];
	assign o_op = mem_op[rptr];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wptr  <= 1'b0;
			rptr  <= 1'b0;
			count <= 2'd0;
		end else begin
			if (push) wptr <= ~wptr;
			if (pop)  rptr <= ~rptr;
			count <= count + {1'b0, push} - {1'b0, pop};
		end
	end

	always_ff @(posedge i_clk) begin
		if (push) begin
			mem_id[wptr] <= i_id;
			mem_ax[wptr] <= i_ax;
			mem_ay[wptr] <= i_ay;
			mem_op[wptr] <= i_op;
		end
	end

	a_count_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		count <= 2'd2)
		else $error("step FIFO count %0d above depth", count);

	// The consumer must not take an entry that is not there
	a_no_empty_read: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_ack |-> (count != 2'd0))
		else $error("step FIFO read while empty");

endmodule

`default_nettype wire

// ==== warp_vector_addr.sv ====
`timescale 1ns/1ps
`include "warp_looper_defs.svh"
`default_nettype none

module warp_vector_addr import warp_looper_pkg::*; (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	// Step input
	input  logic                 i_rdy,
	output logic                 o_ack,
	input  logic [`WL_IDW-1:0]   i_id,
	input  logic [`WL_WBW-1:0]   i_ax,
	input  logic [`WL_WBW-1:0]   i_ay,
	input  step_op_e             i_op,
	// B offset and static configuration
	input  logic [`WL_WBW-1:0]   i_bofs,
	input  logic [`WL_WBW-1:0]   i_bboundary,
	input  logic [`WL_ABW-1:0]   i_linears   [`WL_NCFG],
	input  logic [`WL_ABW-1:0]   i_astride_x [`WL_NCFG],
	input  logic [`WL_ABW-1:0]   i_astride_y [`WL_NCFG],
	input  logic [`WL_ABW-1:0]   i_lane_step [`WL_NCFG],
	// Vector output
	output logic                 o_rdy,
	input  logic                 i_ack,
	output logic [`WL_IDW-1:0]   o_id,
	output logic [`WL_ABW-1:0]   o_address [`WL_VSIZE],
	output logic [`WL_VSIZE-1:0] o_valid,
	output logic                 o_retire
);

	localparam int ABW   = `WL_ABW;
	localparam int WBW   = `WL_WBW;
	localparam int VSIZE = `WL_VSIZE;

	// ========================================
	// Address computation
	// ========================================

	logic [ABW-1:0]       base_addr;
	logic [ABW-1:0]       lane_addr [VSIZE];
	logic [VSIZE-1:0]     lane_ok;
	logic [VSIZE*ABW-1:0] addr_flat;

	// Base address is the linear start plus both A strides modulo 2^ABW
	always_comb begin
		base_addr = i_linears[i_id]
			+ ABW'(i_ax) * i_astride_x[i_id]
			+ ABW'(i_ay) * i_astride_y[i_id];
		for (int j = 0; j < VSIZE; j++) begin
			lane_addr[j] = base_addr + (ABW'(i_bofs) + ABW'(j)) * i_lane_step[i_id];
			// Extra bit keeps bofs + j from wrapping past the boundary
			lane_ok[j] = ({1'b0, i_bofs} + (WBW+1)'(j)) < {1'b0, i_bboundary};
		end
	end

	// ========================================
	// Output register
	// ========================================

	// Take a step when the register is free or drains this cycle
	assign o_ack = i_rdy && (!o_rdy || i_ack);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_rdy <= 1'b0;
		end else if (o_ack) begin
			o_rdy <= 1'b1;
		end else if (i_ack) begin
			o_rdy <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_ack) begin
			o_id      <= i_id;
			o_address <= lane_addr;
			o_valid   <= lane_ok;
			o_retire  <= (i_op == STEP_LAST);
		end
	end

	// Packed view of all lanes for the hold check
	always_comb begin
		for (int j = 0; j < VSIZE; j++) begin
			addr_flat[j*ABW +: ABW] = o_address[j];
		end
	end

	a_hold_output: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(o_rdy && !i_ack) |=> (o_rdy && $stable(o_id) && $stable(addr_flat)
			&& $stable(o_valid) && $stable(o_retire)))
		else $error("vector output changed while stalled");

endmodule

`default_nettype wire

// ==== accum_warp_looper.sv ====
`timescale 1ns/1ps
`include "warp_looper_defs.svh"
`default_nettype none

module accum_warp_looper import warp_looper_pkg::*; (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	// Command
	input  logic                 i_cmd_rdy,
	output logic                 o_cmd_ack,
	input  logic [`WL_WBW-1:0]   i_bofs,
	input  logic [`WL_WBW-1:0]   i_bboundary,
	input  logic [`WL_WBW-1:0]   i_abeg_x,
	input  logic [`WL_WBW-1:0]   i_abeg_y,
	input  logic [`WL_WBW-1:0]   i_aend_x,
	input  logic [`WL_WBW-1:0]   i_aend_y,
	input  logic [`WL_IDW:0]     i_id_beg,
	input  logic [`WL_IDW:0]     i_id_end,
	// Static configuration
	input  logic [`WL_ABW-1:0]   i_linears   [`WL_NCFG],
	input  logic [`WL_ABW-1:0]   i_astride_x [`WL_NCFG],
	input  logic [`WL_ABW-1:0]   i_astride_y [`WL_NCFG],
	input  logic [`WL_ABW-1:0]   i_lane_step [`WL_NCFG],
	// Address vectors
	output logic                 o_addrval_rdy,
	input  logic                 i_addrval_ack,
	output logic [`WL_IDW-1:0]   o_id,
	output logic [`WL_ABW-1:0]   o_address [`WL_VSIZE],
	output logic [`WL_VSIZE-1:0] o_valid,
	output logic                 o_retire
);

	// Producer to FIFO
	logic               step_rdy;
	logic               step_ack;
	logic [`WL_IDW-1:0] s_id;
	logic [`WL_WBW-1:0] s_ax;
	logic [`WL_WBW-1:0] s_ay;
	step_op_e           s_op;

	// FIFO to consumer
	logic               vec_rdy;
	logic               vec_ack;
	logic [`WL_IDW-1:0] v_id;
	logic [`WL_WBW-1:0] v_ax;
	logic [`WL_WBW-1:0] v_ay;
	step_op_e           v_op;

	warp_index_loop u_loop (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_cmd_rdy  (i_cmd_rdy),
		.o_cmd_ack  (o_cmd_ack),
		.i_abeg_x   (i_abeg_x),
		.i_abeg_y   (i_abeg_y),
		.i_aend_x   (i_aend_x),
		.i_aend_y   (i_aend_y),
		.i_id_beg   (i_id_beg),
		.i_id_end   (i_id_end),
		.o_step_rdy (step_rdy),
		.i_step_ack (step_ack),
		.o_id       (s_id),
		.o_ax       (s_ax),
		.o_ay       (s_ay),
		.o_op       (s_op)
	);

	warp_step_fifo u_fifo (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_rdy   (step_rdy),
		.o_ack   (step_ack),
		.i_id    (s_id),
		.i_ax    (s_ax),
		.i_ay    (s_ay),
		.i_op    (s_op),
		.o_rdy   (vec_rdy),
		.i_ack   (vec_ack),
		.o_id    (v_id),
		.o_ax    (v_ax),
		.o_ay    (v_ay),
		.o_op    (v_op)
	);

	warp_vector_addr u_vec (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_rdy       (vec_rdy),
		.o_ack       (vec_ack),
		.i_id        (v_id),
		.i_ax        (v_ax),
		.i_ay        (v_ay),
		.i_op        (v_op),
		.i_bofs      (i_bofs),
		.i_bboundary (i_bboundary),
		.i_linears   (i_linears),
		.i_astride_x (i_astride_x),
		.i_astride_y (i_astride_y),
		.i_lane_step (i_lane_step),
		.o_rdy       (o_addrval_rdy),
		.i_ack       (i_addrval_ack),
		.o_id        (o_id),
		.o_address   (o_address),
		.o_valid     (o_valid),
		.o_retire    (o_retire)
	);

endmodule

`default_nettype wire

// ==== tb_clk_rst.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_rst (
	output logic o_clk,
	output logic o_rst_n
);

	// 8 ns period
	initial begin
		o_clk = 1'b0;
		forever begin
			#4 o_clk = ~o_clk;
		end
	end

	// Reset held low for three rising edges
	initial begin
		o_rst_n = 1'b0;
		repeat (3) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb_accum_warp_looper.sv ====
`timescale 1ns/1ps
`include "warp_looper_defs.svh"
`default_nettype none

module tb_accum_warp_looper import warp_looper_pkg::*; ();

	localparam int NUM_CMDS      = 40;
	localparam int CMD_TIMEOUT   = 50;
	localparam int DRAIN_TIMEOUT = 1000;

	typedef struct packed {
		logic [`WL_IDW-1:0]          id;
		logic [`WL_VSIZE*`WL_ABW-1:0] addr;
		logic [`WL_VSIZE-1:0]        valid;
		logic                        retire;
	} exp_vec_t;

	logic clk;
	logic rst_n;

	logic               cmd_rdy;
	logic               cmd_ack;
	logic [`WL_WBW-1:0] bofs, bboundary, abeg_x, abeg_y, aend_x, aend_y;
	logic [`WL_IDW:0]   id_beg, id_end;
	logic [`WL_ABW-1:0] linears   [`WL_NCFG];
	logic [`WL_ABW-1:0] astride_x [`WL_NCFG];
	logic [`WL_ABW-1:0] astride_y [`WL_NCFG];
	logic [`WL_ABW-1:0] lane_step [`WL_NCFG];

	logic                          addrval_rdy;
	logic                          addrval_ack;
	logic [`WL_IDW-1:0]            out_id;
	logic [`WL_ABW-1:0]            out_address [`WL_VSIZE];
	logic [`WL_VSIZE-1:0]          out_valid;
	logic                          out_retire;
	logic [`WL_VSIZE*`WL_ABW-1:0]  out_addr_flat;

	// Next command built before it is driven
	logic [`WL_WBW-1:0] nx_bofs, nx_bboundary, nx_abeg_x, nx_abeg_y, nx_aend_x, nx_aend_y;
	logic [`WL_IDW:0]   nx_id_beg, nx_id_end;

	exp_vec_t    exp_q [$];
	exp_vec_t    head;
	logic        head_present = 1'b0;
	loop_state_e model_state  = LOOP_IDLE;
	logic [31:0] lfsr_state   = 32'hf5225c9b;
	logic        ack_dense    = 1'b1;
	logic        cmd_seen     = 1'b0;
	logic        timed_out    = 1'b0;
	int          errors       = 0;

	tb_clk_rst u_clk_rst (.o_clk(clk), .o_rst_n(rst_n));

	accum_warp_looper dut (
		.i_clk(clk), .i_rst_n(rst_n),
		.i_cmd_rdy(cmd_rdy), .o_cmd_ack(cmd_ack),
		.i_bofs(bofs), .i_bboundary(bboundary),
		.i_abeg_x(abeg_x), .i_abeg_y(abeg_y), .i_aend_x(aend_x), .i_aend_y(aend_y),
		.i_id_beg(id_beg), .i_id_end(id_end),
		.i_linears(linears), .i_astride_x(astride_x),
		.i_astride_y(astride_y), .i_lane_step(lane_step),
		.o_addrval_rdy(addrval_rdy), .i_addrval_ack(addrval_ack),
		.o_id(out_id), .o_address(out_address), .o_valid(out_valid), .o_retire(out_retire)
	);

	always_comb begin
		for (int j = 0; j < `WL_VSIZE; j++) begin
			out_addr_flat[j*`WL_ABW +: `WL_ABW] = out_address[j];
		end
	end

	// ========================================
	// Random source and helpers
	// ========================================

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		errors++;
		$display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
	endtask

	// One clock edge with a fresh random sink ack
	task automatic step_cycle();
		logic [31:0] r;
		@(posedge clk);
		take_bits(2, r);
		addrval_ack <= ack_dense ? (r[1:0] != 2'b00) : (r[1:0] == 2'b11);
	endtask

	// ========================================
	// Reference model
	// ========================================

	// Row-major walk over A with id fastest and one vector per item
	task automatic push_expected();
		exp_vec_t    v;
		logic [31:0] a;
		for (int ay = int'(abeg_y); ay < int'(aend_y); ay++) begin
			for (int ax = int'(abeg_x); ax < int'(aend_x); ax++) begin
				for (int k = int'(id_beg); k < int'(id_end); k++) begin
					v.id = k[`WL_IDW-1:0];
					for (int j = 0; j < `WL_VSIZE; j++) begin
						a = linears[k] + ax * astride_x[k] + ay * astride_y[k]
							+ (int'(bofs) + j) * lane_step[k];
						v.addr[j*`WL_ABW +: `WL_ABW] = a[`WL_ABW-1:0];
						v.valid[j] = (int'(bofs) + j) < int'(bboundary);
					end
					v.retire = (ay == int'(aend_y) - 1) && (ax == int'(aend_x) - 1)
						&& (k == int'(id_end) - 1);
					exp_q.push_back(v);
					model_state = LOOP_RUN;
				end
			end
		end
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			if (addrval_rdy && addrval_ack && exp_q.size() != 0) begin
				if (exp_q[0].retire) model_state = LOOP_IDLE;
				exp_q.delete(0);
			end
			if (cmd_ack) push_expected();
		end
		if (exp_q.size() != 0) begin
			head         <= exp_q[0];
			head_present <= 1'b1;
		end else begin
			head_present <= 1'b0;
		end
	end

	// ========================================
	// Checks
	// ========================================

	a_vec_expected: assert property (@(posedge clk) disable iff (!rst_n)
		(addrval_rdy && addrval_ack) |-> head_present)
		else begin
			errors++;
			$display("A vector was accepted while the model expected none");
		end

	a_vec_id: assert property (@(posedge clk) disable iff (!rst_n)
		(addrval_rdy && addrval_ack && head_present) |-> (out_id == head.id))
		else report_mismatch("id", $sampled(head.id), $sampled(out_id));

	a_vec_address: assert property (@(posedge clk) disable iff (!rst_n)
		(addrval_rdy && addrval_ack && head_present) |-> (out_addr_flat == head.addr))
		else report_mismatch("address", $sampled(head.addr), $sampled(out_addr_flat));

	a_vec_valid: assert property (@(posedge clk) disable iff (!rst_n)
		(addrval_rdy && addrval_ack && head_present) |-> (out_valid == head.valid))
		else report_mismatch("valid", $sampled(head.valid), $sampled(out_valid));

	a_vec_retire: assert property (@(posedge clk) disable iff (!rst_n)
		(addrval_rdy && addrval_ack && head_present) |-> (out_retire == head.retire))
		else report_mismatch("retire", $sampled(head.retire), $sampled(out_retire));

	a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
		(addrval_rdy && !addrval_ack) |=> (addrval_rdy && $stable(out_id)
			&& $stable(out_addr_flat) && $stable(out_valid) && $stable(out_retire)))
		else begin
			errors++;
			$display("Output vector changed while the sink was stalling");
		end

	// Quiet outputs out of reset until the first command
	a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
		!cmd_seen |-> (!cmd_ack && !addrval_rdy))
		else begin
			errors++;
			$display("Handshake output went high before any command was sent");
		end

	// ========================================
	// Stimulus
	// ========================================

	task automatic pick_command(input int n);
		logic [31:0] r;
		int          span;
		take_bits(2, r);
		nx_id_beg = {1'b0, r[1:0]};
		take_bits(2, r);
		span = 1 + int'(r[1:0]) % (4 - int'(nx_id_beg));
		nx_id_end = nx_id_beg + span[`WL_IDW:0];
		take_bits(8, r);
		nx_abeg_x = 8'(r % 240);
		take_bits(2, r);
		nx_aend_x = nx_abeg_x + 8'(1 + r % 3);
		take_bits(8, r);
		nx_abeg_y = 8'(r % 240);
		take_bits(2, r);
		nx_aend_y = nx_abeg_y + 8'(1 + r % 3);
		take_bits(8, r);
		nx_bofs = 8'(r % 250);
		take_bits(3, r);
		if (r < 6) begin
			nx_bboundary = nx_bofs + 8'(r);
		end else begin
			take_bits(8, r);
			nx_bboundary = r[7:0];
		end
		// Empty ranges at fixed points of the sequence
		if (n % 6 == 2) nx_id_end = nx_id_beg;
		if (n % 12 == 4) nx_aend_x = nx_abeg_x;
		if (n % 12 == 10) nx_aend_y = nx_abeg_y;
		take_bits(1, r);
		ack_dense = r[0];
	endtask

	task automatic issue_command();
		int waited;
		step_cycle();
		cmd_rdy   <= 1'b1;
		bofs      <= nx_bofs;
		bboundary <= nx_bboundary;
		abeg_x    <= nx_abeg_x;
		abeg_y    <= nx_abeg_y;
		aend_x    <= nx_aend_x;
		aend_y    <= nx_aend_y;
		id_beg    <= nx_id_beg;
		id_end    <= nx_id_end;
		cmd_seen = 1'b1;
		waited = 0;
		step_cycle();
		while (!cmd_ack && waited < CMD_TIMEOUT) begin
			step_cycle();
			waited++;
		end
		if (!cmd_ack) begin
			timed_out = 1'b1;
			errors++;
			$display("Timeout: the command was never acknowledged");
		end
		cmd_rdy <= 1'b0;
	endtask

	// B offset stays put until every vector of the command is out
	task automatic drain_vectors();
		int waited;
		step_cycle();
		waited = 1;
		while ((model_state != LOOP_IDLE || exp_q.size() != 0) && waited < DRAIN_TIMEOUT) begin
			step_cycle();
			waited++;
		end
		if (model_state != LOOP_IDLE || exp_q.size() != 0) begin
			timed_out = 1'b1;
			errors++;
			$display("Timeout: %0d expected vectors never came out", exp_q.size());
		end
	endtask

	initial begin : main_seq
		logic [31:0] r;
		int          waited;
		cmd_rdy     = 1'b0;
		addrval_ack = 1'b0;
		bofs        = '0;
		bboundary   = '0;
		abeg_x      = '0;
		abeg_y      = '0;
		aend_x      = '0;
		aend_y      = '0;
		id_beg      = '0;
		id_end      = '0;
		for (int k = 0; k < `WL_NCFG; k++) begin
			take_bits(16, r);
			linears[k] = r[15:0];
			take_bits(16, r);
			astride_x[k] = r[15:0];
			take_bits(16, r);
			astride_y[k] = r[15:0];
			take_bits(16, r);
			lane_step[k] = r[15:0];
		end

		waited = 0;
		while (!rst_n && waited < 20) begin
			step_cycle();
			waited++;
		end
		if (!rst_n) begin
			timed_out = 1'b1;
			errors++;
			$display("Timeout: reset was never released");
		end

		// Idle a while so the reset quiet check gets exercised
		for (int i = 0; i < 5; i++) step_cycle();

		for (int n = 0; n < NUM_CMDS && !timed_out; n++) begin
			pick_command(n);
			issue_command();
			if (!timed_out) drain_vectors();
		end

		// Trailing idle cycles catch any vector beyond the last command
		if (!timed_out) begin
			ack_dense = 1'b1;
			for (int i = 0; i < 10; i++) step_cycle();
		end

		$display("Test finished with %0d errors", errors);
		if (errors == 0 && !timed_out) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
warp_looper_pkg.sv
warp_index_loop.sv
warp_step_fifo.sv
warp_vector_addr.sv
accum_warp_looper.sv
tb_clk_rst.sv
tb_accum_warp_looper.sv

// ==== Bender.yml ====
package:
  name: accum_warp_looper

export_include_dirs:
  - .

sources:
  - warp_looper_pkg.sv
  - warp_index_loop.sv
  - warp_step_fifo.sv
  - warp_vector_addr.sv
  - accum_warp_looper.sv
  - target: test
    files:
      - tb_clk_rst.sv
      - tb_accum_warp_looper.sv
